//--- build.f
+incdir+logic
logic/fft16_pkg.sv
logic/sample_collector.sv
logic/butterfly.sv
logic/fft_core.sv
logic/result_serializer.sv
logic/stream_end_monitor.sv
logic/fft16_top.sv
bench/fft16_clock.sv
bench/fft16_asserts.sv
bench/fft16_tb.sv

//--- bench/fft16_tb.sv
`timescale 1ns/10ps
`include "fft16_defs.svh"

module fft16_tb;

    import fft16_pkg::*;

    localparam int TIMEOUT     = 64;
    localparam int K_IMPULSE   = 0;
    localparam int K_CONSTANT  = 1;
    localparam int K_ALTERNATE = 2;

    logic        clk;
    logic        rst;
    sample_t     in_sample;
    logic        in_valid;
    bin_row_t    out_bins;
    logic        out_valid;
    logic        done;

    logic [31:0] lfsr_state = 32'h52499ce1;
    int          cycle = 0;
    int          e0_cycle = 0;
    int          fail_count = 0;
    bin_row_t    row_q [$];
    int          row_cycle_q [$];
    int          done_q [$];

    fft16_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    fft16_top fft16_top_i (
        .clk       (clk),
        .rst       (rst),
        .in_sample (in_sample),
        .in_valid  (in_valid),
        .out_bins  (out_bins),
        .out_valid (out_valid),
        .done      (done)
    );

    ////////////////////////////////////////
    // capture and failure handling
    ////////////////////////////////////////

    always @(posedge clk) cycle <= cycle + 1;

    always @(negedge clk) begin
        if (out_valid) begin
            row_q.push_back(out_bins);
            row_cycle_q.push_back(cycle);
        end
        if (done) begin
            done_q.push_back(cycle);
        end
        if (fft16_top_i.fft16_asserts_i.failures != 0) begin
            stop_with_failure("a protocol assertion failed");
        end
    end

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            fail_count++;
            stop_with_failure($sformatf("ERROR %s: expected %0d, actual %0d",
                                        name, expected, actual));
        end
    endtask

    ////////////////////////////////////////
    // stimulus and expected bins
    ////////////////////////////////////////

    // galois lfsr, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    // 10 bit signed, never zero
    function automatic sample_t random_amp();
        logic [9:0] r;
        r = random_bits(10);
        if (r == '0) begin
            r = 10'd1;
        end
        return sample_t'($signed(r));
    endfunction

    function automatic sample_t pattern(input int kind, input sample_t v, input int n);
        case (kind)
            K_IMPULSE:  return (n == 0) ? v : '0;
            K_CONSTANT: return v;
            default:    return n[0] ? -v : v;
        endcase
    endfunction

    // imaginary bins are zero for all three patterns
    function automatic int expected_re(input int kind, input sample_t v, input int k);
        case (kind)
            K_IMPULSE:  return v;
            K_CONSTANT: return (k == 0) ? `FFT_POINTS * v : 0;
            default:    return (k == `FFT_POINTS / 2) ? `FFT_POINTS * v : 0;
        endcase
    endfunction

    task automatic drive_sample(input sample_t s, input logic valid);
        @(posedge clk);
        #1;
        in_sample = s;
        in_valid  = valid;
    endtask

    task automatic send_frame(input int kind, input sample_t v, input logic with_gaps);
        for (int n = 0; n < `FFT_POINTS; n++) begin
            if (with_gaps && n > 0 && random_bits(1) != 0) begin
                drive_sample('0, 1'b0);
            end
            drive_sample(pattern(kind, v, n), 1'b1);
        end
    endtask

    // this edge takes the last sample
    task automatic close_stream();
        drive_sample('0, 1'b0);
        e0_cycle = cycle;
    endtask

    task automatic wait_rows(input int count, input string what);
        int waited;
        waited = 0;
        while (row_q.size() < count && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (row_q.size() < count) begin
            stop_with_failure($sformatf("timed out waiting for the output rows of %s", what));
        end
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (done_q.size() == 0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (done_q.size() == 0) begin
            stop_with_failure("timed out waiting for done after the stream ended");
        end
    endtask

    task automatic settle();
        repeat (8) @(posedge clk);
        row_q.delete();
        row_cycle_q.delete();
        done_q.delete();
    endtask

    task automatic check_frame(input string name, input int kind, input sample_t v,
                               input int first);
        for (int k = 0; k < `FFT_POINTS; k++) begin
            check_value($sformatf("%s re[%0d]", name, k), expected_re(kind, v, k),
                        row_q[first][k]);
            check_value($sformatf("%s im[%0d]", name, k), 0, row_q[first + 1][k]);
        end
    endtask

    task automatic run_single(input string name, input int kind, input logic with_gaps);
        sample_t v;
        v = random_amp();
        send_frame(kind, v, with_gaps);
        close_stream();
        wait_rows(2, name);
        check_frame(name, kind, v, 0);
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        int      waited;
        sample_t amp [3];
        in_sample = '0;
        in_valid  = 1'b0;
        waited    = 0;
        while (rst !== 1'b0 && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst !== 1'b0) begin
            stop_with_failure("reset was never released");
        end

        settle();
        run_single("impulse", K_IMPULSE, 1'b0);
        settle();
        run_single("constant", K_CONSTANT, 1'b0);
        settle();
        run_single("alternating", K_ALTERNATE, 1'b0);
        settle();
        run_single("gaps", K_IMPULSE, 1'b1);
        check_value("gaps real beat edge", e0_cycle + 6, row_cycle_q[0]);
        check_value("gaps imag beat edge", e0_cycle + 7, row_cycle_q[1]);
        repeat (4) @(posedge clk);
        check_value("gaps beat count", 2, row_q.size());

        // three frames with no break in in_valid
        settle();
        for (int f = 0; f < 3; f++) begin
            amp[f] = random_amp();
            send_frame(f, amp[f], 1'b0);
        end
        close_stream();
        wait_rows(6, "the stream");
        wait_done();
        repeat (4) @(posedge clk);
        for (int f = 0; f < 3; f++) begin
            check_frame($sformatf("stream frame %0d", f), f, amp[f], 2 * f);
        end
        check_value("stream done pulses", 1, done_q.size());
        // one cycle after out_valid is back low
        check_value("stream done cycle", row_cycle_q[5] + 2, done_q[0]);

        if (fail_count == 0 && fft16_top_i.fft16_asserts_i.failures == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_with_failure("one or more checks failed");
        end
    end

endmodule

//--- bench/fft16_asserts.sv
`timescale 1ns/10ps

module fft16_asserts (
    input logic clk,
    input logic rst,
    input logic frame_ready,
    input logic out_valid,
    input logic done
);

    // read by the testbench
    int failures = 0;

    // quiet while in reset and one cycle after
    reset_quiet: assert property (@(posedge clk) (rst || $past(rst)) |-> (!out_valid && !done))
        else begin
            failures++;
            $error("out_valid or done high around reset");
        end

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            failures++;
            $error("done high for two cycles");
        end

    valid_two_beats: assert property (@(posedge clk) disable iff (rst)
        (out_valid ##1 out_valid) |=> !out_valid)
        else begin
            failures++;
            $error("out_valid high for more than two cycles");
        end

    // real beat six edges after the last sample, then the imaginary beat
    beat_timing: assert property (@(posedge clk) disable iff (rst)
        frame_ready |-> !out_valid [*6] ##1 out_valid [*2] ##1 !out_valid)
        else begin
            failures++;
            $error("output beats off their schedule after a frame");
        end

endmodule

bind fft16_top fft16_asserts fft16_asserts_i (
    .clk         (clk),
    .rst         (rst),
    .frame_ready (frame_ready),
    .out_valid   (out_valid),
    .done        (done)
);

//--- bench/fft16_clock.sv
`timescale 1ns/10ps

module fft16_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- logic/fft16_top.sv
`timescale 1ns/10ps

module fft16_top (
    input  logic                clk,
    input  logic                rst,
    input  fft16_pkg::sample_t  in_sample,
    input  logic                in_valid,
    output fft16_pkg::bin_row_t out_bins,
    output logic                out_valid,
    output logic                done
);

    import fft16_pkg::*;

    frame_t    frame;
    logic      frame_ready;
    spectrum_t spectrum;
    logic      result_ready;

    sample_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .in_sample   (in_sample),
        .in_valid    (in_valid),
        .frame       (frame),
        .frame_ready (frame_ready)
    );

    fft_core u_core (
        .clk          (clk),
        .rst          (rst),
        .frame        (frame),
        .frame_ready  (frame_ready),
        .spectrum     (spectrum),
        .result_ready (result_ready)
    );

    result_serializer u_serializer (
        .clk          (clk),
        .rst          (rst),
        .spectrum     (spectrum),
        .result_ready (result_ready),
        .out_bins     (out_bins),
        .out_valid    (out_valid)
    );

    stream_end_monitor u_monitor (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .done      (done)
    );

endmodule

//--- logic/stream_end_monitor.sv
`timescale 1ns/10ps

module stream_end_monitor (
    input  logic clk,
    input  logic rst,
    input  logic in_valid,
    input  logic out_valid,
    output logic done
);

    logic in_valid_q;
    logic out_valid_q;
    logic armed;
    logic in_end;
    logic out_end;

    // falling edges of both streams
    assign in_end  = in_valid_q && !in_valid;
    assign out_end = out_valid_q && !out_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_valid_q  <= 1'b0;
            out_valid_q <= 1'b0;
            armed       <= 1'b0;
            done        <= 1'b0;
        end else begin
            in_valid_q  <= in_valid;
            out_valid_q <= out_valid;
            done        <= armed && out_end;
            // a fresh end of input always re-arms
            if (in_end) begin
                armed <= 1'b1;
            end else if (out_end) begin
                armed <= 1'b0;
            end
        end
    end

endmodule

//--- logic/result_serializer.sv
`timescale 1ns/10ps

module result_serializer (
    input  logic                 clk,
    input  logic                 rst,
    input  fft16_pkg::spectrum_t spectrum,
    input  logic                 result_ready,
    output fft16_pkg::bin_row_t  out_bins,
    output logic                 out_valid
);

    // high while the imaginary beat is due
    logic im_phase;

    ////////////////////////////////////////
    // beat control
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            im_phase  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= result_ready || im_phase;
            // real beat now, imaginary beat on the next edge
            im_phase  <= result_ready;
        end
    end

    ////////////////////////////////////////
    // output row
    ////////////////////////////////////////

    // keeps the last beat once out_valid drops
    always_ff @(posedge clk) begin
        if (result_ready) begin
            out_bins <= spectrum.re;
        end else if (im_phase) begin
            out_bins <= spectrum.im;
        end
    end

endmodule

//--- logic/fft_core.sv
`timescale 1ns/10ps
`include "fft16_defs.svh"

module fft_core (
    input  logic                 clk,
    input  logic                 rst,
    input  fft16_pkg::frame_t    frame,
    input  logic                 frame_ready,
    output fft16_pkg::spectrum_t spectrum,
    output logic                 result_ready
);

    import fft16_pkg::*;

    localparam int IDX_W = $clog2(`FFT_POINTS);
    localparam int HALF  = `FFT_POINTS / 2;
    localparam int STG_W = $clog2(`STAGES);

    typedef enum logic [2:0] {
        S_IDLE,
        S_STAGE1,
        S_STAGE2,
        S_STAGE3,
        S_STAGE4,
        S_DONE
    } core_state_t;

    core_state_t state;

    cplx_t buf_a [`FFT_POINTS];
    cplx_t buf_b [`FFT_POINTS];

    logic [STG_W-1:0] stage_idx;
    logic             src_is_b;
    logic [IDX_W-1:0] idx_a  [HALF];
    logic [IDX_W-1:0] idx_b  [HALF];
    logic [IDX_W-2:0] tw_idx [HALF];
    cplx_t            bf_sum  [HALF];
    cplx_t            bf_diff [HALF];

    // cos and -sin of 2*pi*k/16 in Q16.16
    function automatic cplx_t twiddle(input logic [IDX_W-2:0] k);
        cplx_t w;
        case (k)
            3'd0:    w = '{re: 32'sh0001_0000, im: 32'sh0000_0000};
            3'd1:    w = '{re: 32'sh0000_EC83, im: 32'shFFFF_9E09};
            3'd2:    w = '{re: 32'sh0000_B504, im: 32'shFFFF_4AFC};
            3'd3:    w = '{re: 32'sh0000_61F7, im: 32'shFFFF_137D};
            3'd4:    w = '{re: 32'sh0000_0000, im: 32'shFFFF_0000};
            3'd5:    w = '{re: 32'shFFFF_9E09, im: 32'shFFFF_137D};
            3'd6:    w = '{re: 32'shFFFF_4AFC, im: 32'shFFFF_4AFC};
            default: w = '{re: 32'shFFFF_137D, im: 32'shFFFF_9E09};
        endcase
        return w;
    endfunction

    function automatic logic [IDX_W-1:0] bit_rev(input logic [IDX_W-1:0] v);
        return {v[0], v[1], v[2], v[3]};
    endfunction

    ////////////////////////////////////////
    // stage sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:   if (frame_ready) state <= S_STAGE1;
                S_STAGE1: state <= S_STAGE2;
                S_STAGE2: state <= S_STAGE3;
                S_STAGE3: state <= S_STAGE4;
                S_STAGE4: state <= S_DONE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    assign result_ready = (state == S_DONE);

    always_comb begin
        case (state)
            S_STAGE2: stage_idx = STG_W'(1);
            S_STAGE3: stage_idx = STG_W'(2);
            S_STAGE4: stage_idx = STG_W'(3);
            default:  stage_idx = '0;
        endcase
    end

    // odd stages read a, even stages read b
    assign src_is_b = (state == S_STAGE2) || (state == S_STAGE4);

    ////////////////////////////////////////
    // index schedule
    ////////////////////////////////////////

    always_comb begin
        logic [IDX_W-1:0] span;
        logic [IDX_W-1:0] offset;
        span = IDX_W'(HALF >> stage_idx);
        for (int k = 0; k < HALF; k++) begin
            // position within the group of span butterflies
            offset    = IDX_W'(k) & (span - 1'b1);
            idx_a[k]  = IDX_W'(2 * k) - offset;
            idx_b[k]  = idx_a[k] + span;
            tw_idx[k] = (IDX_W - 1)'(offset << stage_idx);
        end
    end

    ////////////////////////////////////////
    // butterfly row
    ////////////////////////////////////////

    for (genvar k = 0; k < HALF; k++) begin : g_bf
        cplx_t src_a;
        cplx_t src_b;

        assign src_a = src_is_b ? buf_b[idx_a[k]] : buf_a[idx_a[k]];
        assign src_b = src_is_b ? buf_b[idx_b[k]] : buf_a[idx_b[k]];

        butterfly u_bf (
            .a    (src_a),
            .b    (src_b),
            .w    (twiddle(tw_idx[k])),
            .sum  (bf_sum[k]),
            .diff (bf_diff[k])
        );
    end

    // ping-pong writeback, stage 4 lands in a
    always_ff @(posedge clk) begin
        case (state)
            S_IDLE: begin
                if (frame_ready) begin
                    for (int i = 0; i < `FFT_POINTS; i++) begin
                        buf_a[i] <= '{re: frame[i], im: '0};
                    end
                end
            end
            S_STAGE1, S_STAGE3: begin
                for (int k = 0; k < HALF; k++) begin
                    buf_b[idx_a[k]] <= bf_sum[k];
                    buf_b[idx_b[k]] <= bf_diff[k];
                end
            end
            S_STAGE2, S_STAGE4: begin
                for (int k = 0; k < HALF; k++) begin
                    buf_a[idx_a[k]] <= bf_sum[k];
                    buf_a[idx_b[k]] <= bf_diff[k];
                end
            end
            default: ;
        endcase
    end

    // bins sit at bit-reversed positions
    always_comb begin
        for (int k = 0; k < `FFT_POINTS; k++) begin
            spectrum.re[k] = buf_a[bit_rev(IDX_W'(k))].re[`GUARD_W+`SAMPLE_W-1:`GUARD_W];
            spectrum.im[k] = buf_a[bit_rev(IDX_W'(k))].im[`GUARD_W+`SAMPLE_W-1:`GUARD_W];
        end
    end

endmodule

//--- logic/butterfly.sv
`timescale 1ns/10ps
`include "fft16_defs.svh"

module butterfly (
    input  fft16_pkg::cplx_t a,
    input  fft16_pkg::cplx_t b,
    input  fft16_pkg::cplx_t w,
    output fft16_pkg::cplx_t sum,
    output fft16_pkg::cplx_t diff
);

    import fft16_pkg::*;

    localparam int PROD_W = 2 * `WORD_W;
    localparam int KEEP_HI = `FRAC_W + `WORD_W - 1;

    word_t d_re;
    word_t d_im;
    word_t w_re;
    word_t w_im;

    logic signed [PROD_W-1:0] p_rr;
    logic signed [PROD_W-1:0] p_ii;
    logic signed [PROD_W-1:0] p_ri;
    logic signed [PROD_W-1:0] p_ir;

    // upper leg
    assign sum = '{re: a.re + b.re, im: a.im + b.im};

    // lower leg, (a - b) * w
    assign d_re = a.re - b.re;
    assign d_im = a.im - b.im;
    assign w_re = w.re;
    assign w_im = w.im;

    assign p_rr = d_re * w_re;
    assign p_ii = d_im * w_im;
    assign p_ri = d_re * w_im;
    assign p_ir = d_im * w_re;

    // back to Q16.16 before the partials meet
    assign diff = '{re: p_rr[KEEP_HI:`FRAC_W] - p_ii[KEEP_HI:`FRAC_W],
                    im: p_ri[KEEP_HI:`FRAC_W] + p_ir[KEEP_HI:`FRAC_W]};

endmodule

//--- logic/sample_collector.sv
`timescale 1ns/10ps
`include "fft16_defs.svh"

module sample_collector (
    input  logic               clk,
    input  logic               rst,
    input  fft16_pkg::sample_t in_sample,
    input  logic               in_valid,
    output fft16_pkg::frame_t  frame,
    output logic               frame_ready
);

    import fft16_pkg::*;

    localparam int IDX_W = $clog2(`FFT_POINTS);
    localparam int EXT_W = `WORD_W - `SAMPLE_W - `GUARD_W;

    logic [IDX_W-1:0] wr_idx;
    word_t            ext_word;

    // sign bits above, guard zeros below
    assign ext_word = {{EXT_W{in_sample[`SAMPLE_W-1]}}, in_sample, {`GUARD_W{1'b0}}};

    ////////////////////////////////////////
    // beat counter
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_idx      <= '0;
            frame_ready <= 1'b0;
        end else begin
            // pulse once the last word of the frame is in
            frame_ready <= in_valid && (wr_idx == IDX_W'(`FFT_POINTS - 1));
            if (in_valid) begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // frame storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (in_valid) begin
            frame[wr_idx] <= ext_word;
        end
    end

endmodule

//--- logic/fft16_pkg.sv
`include "fft16_defs.svh"

package fft16_pkg;

    ////////////////////////////////////////
    // scalar types
    ////////////////////////////////////////

    // raw input sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // internal Q16.16 word
    typedef logic signed [`WORD_W-1:0] word_t;

    // output bin value
    typedef logic signed [`SAMPLE_W-1:0] bin_t;

    ////////////////////////////////////////
    // grouped types
    ////////////////////////////////////////

    // one collected frame, sample n at index n
    typedef word_t [`FFT_POINTS-1:0] frame_t;

    // one row of bins, bin k at index k
    typedef bin_t [`FFT_POINTS-1:0] bin_row_t;

    typedef struct packed {
        bin_row_t re;
        bin_row_t im;
    } spectrum_t;

    // complex word for the butterflies
    typedef struct packed {
        word_t re;
        word_t im;
    } cplx_t;

endpackage

//--- logic/fft16_defs.svh
`ifndef FFT16_DEFS_SVH
`define FFT16_DEFS_SVH

// transform size
`define FFT_POINTS 16
`define STAGES     4

// sample and bin width
`define SAMPLE_W   16

// internal Q16.16 word
`define WORD_W     32
`define FRAC_W     16

// zero bits under the sample inside a word,
// bins come back out of bits GUARD_W+SAMPLE_W-1 : GUARD_W
`define GUARD_W    8

`endif
